// ==== include/soc_boot_params.svh ====
`ifndef SOC_BOOT_PARAMS_SVH
`define SOC_BOOT_PARAMS_SVH

// instruction memory geometry
// depth in 32-bit words
`define ICCM_DEPTH 1024

// word address width, log2 of the depth
`define ICCM_ADDR_W 10

// boot loader
// a received word with this value ends loading and is never written
`define ICCM_END_WORD 32'hFFFF_FFFF

// serial receiver
// width of the run-time bit period, counted in clock cycles
`define BAUD_DIV_W 16

// number of bytes packed into one instruction word
`define LOAD_BYTES 4

// data bits per serial frame
`define UART_DATA_BITS 8

// width of one instruction or data word
`define WORD_W 32

`endif

// ==== hdl/soc_boot_pkg.sv ====
`default_nettype none

`include "soc_boot_params.svh"

package soc_boot_pkg;

  // request from the core fetch port
  // wmask is a bit mask, the RAM reduces it to byte enables
  typedef struct packed {
    logic                    req;
    logic                    we;
    logic [`ICCM_ADDR_W-1:0] addr;
    logic [`WORD_W-1:0]      wdata;
    logic [`WORD_W-1:0]      wmask;
  } fetch_req_t;

  // response to the core fetch port
  // rdata only meaningful while rvalid is high
  typedef struct packed {
    logic               rvalid;
    logic [`WORD_W-1:0] rdata;
  } fetch_rsp_t;

  // loader word register
  // bytes view while the word is assembled, least significant byte first
  // word view for the RAM write and the end marker compare
  typedef union packed {
    logic [`LOAD_BYTES-1:0][7:0] bytes;
    logic [`WORD_W-1:0]          word;
  } load_word_u;

endpackage

`default_nettype wire

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_boot_params.svh"

// 8N1 receiver, bit period given in clock cycles at run time
module uart_rx (
  input  logic                   clock,
  input  logic                   rst_ni,
  input  logic                   rx_i,
  input  logic [`BAUD_DIV_W-1:0] baud_div_i,
  output logic                   rx_dv_o,
  output logic [7:0]             rx_byte_o
);

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP,
    RX_CLEANUP
  } rx_state_e;

  rx_state_e              state_q;
  logic                   rx_meta_q;
  logic                   rx_sync_q;
  logic [`BAUD_DIV_W-1:0] clk_cnt_q;
  logic [`BAUD_DIV_W-1:0] bit_last;
  logic [`BAUD_DIV_W-1:0] half_last;
  logic [2:0]             bit_idx_q;
  logic [7:0]             shift_q;
  logic                   bit_end;
  logic                   sample_data;
  logic                   stop_ok;

  // counter end values for a full bit and for half a bit
  assign bit_last  = baud_div_i - 1'b1;
  assign half_last = bit_last >> 1;

  assign bit_end     = (clk_cnt_q == bit_last);
  assign sample_data = (state_q == RX_DATA) && bit_end;
  // a low stop bit is a framing error, the byte is dropped
  assign stop_ok     = (state_q == RX_STOP) && bit_end && rx_sync_q;

  // two flop synchronizer, line idles high
  always_ff @(posedge clock) begin
    if (!rst_ni) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_ni) begin
      state_q   <= RX_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      rx_dv_o   <= 1'b0;
    end else begin
      rx_dv_o <= stop_ok;
      case (state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          if (!rx_sync_q) begin
            state_q <= RX_START;
          end
        end
        // recheck the line in the middle of the start bit
        RX_START: begin
          if (clk_cnt_q == half_last) begin
            clk_cnt_q <= '0;
            state_q   <= rx_sync_q ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            clk_cnt_q <= '0;
            if (bit_idx_q == 3'(`UART_DATA_BITS - 1)) begin
              state_q <= RX_STOP;
            end else begin
              bit_idx_q <= bit_idx_q + 1'b1;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            clk_cnt_q <= '0;
            state_q   <= RX_CLEANUP;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        RX_CLEANUP: begin
          state_q <= RX_IDLE;
        end
        default: begin
          state_q <= RX_IDLE;
        end
      endcase
    end
  end

  // data path, lsb first
  always_ff @(posedge clock) begin
    if (sample_data) begin
      shift_q[bit_idx_q] <= rx_sync_q;
    end
    if (stop_ok) begin
      rx_byte_o <= shift_q;
    end
  end

  // the strobe is a single cycle per frame
  a_dv_single: assert property (@(posedge clock) disable iff (!rst_ni)
    rx_dv_o |=> !rx_dv_o);

endmodule

`default_nettype wire

// ==== hdl/iccm_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_boot_params.svh"

// packs received bytes into words and fills the ICCM from word 0 up
// holds the core in reset until the end marker arrives
module iccm_loader
  import soc_boot_pkg::*;
(
  input  logic                    clock,
  input  logic                    rst_ni,
  input  logic                    rx_dv_i,
  input  logic [7:0]              rx_byte_i,
  output logic                    we_o,
  output logic [`ICCM_ADDR_W-1:0] addr_o,
  output logic [`WORD_W-1:0]      wdata_o,
  output logic                    core_rst_no
);

  load_word_u              word_q;
  load_word_u              word_d;
  logic [1:0]              byte_cnt_q;
  logic [`ICCM_ADDR_W-1:0] addr_q;
  logic                    we_q;
  logic                    done_q;
  logic                    byte_ok;
  logic                    word_full;
  logic                    is_end;

  // bytes after the end marker are ignored
  assign byte_ok   = rx_dv_i & ~done_q;
  assign word_full = byte_ok & (byte_cnt_q == 2'(`LOAD_BYTES - 1));

  // drop the new byte into its lane
  // first byte lands in the lsb
  always_comb begin
    word_d = word_q;
    word_d.bytes[byte_cnt_q] = rx_byte_i;
  end

  assign is_end = (word_d.word == `ICCM_END_WORD);

  always_ff @(posedge clock) begin
    if (byte_ok) begin
      word_q <= word_d;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_ni) begin
      byte_cnt_q <= '0;
      addr_q     <= '0;
      we_q       <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      // write the word one cycle after its last byte
      we_q <= word_full & ~is_end;
      if (byte_ok) begin
        byte_cnt_q <= byte_cnt_q + 1'b1;
      end
      // end marker releases the core for good
      if (word_full && is_end) begin
        done_q <= 1'b1;
      end
      // next word address once the write has gone out
      if (we_q) begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  assign we_o        = we_q;
  assign addr_o      = addr_q;
  assign wdata_o     = word_q.word;
  assign core_rst_no = done_q;

  // the loader never writes once the core is running
  a_no_write_after_boot: assert property (@(posedge clock) disable iff (!rst_ni)
    we_o |-> !core_rst_no);

endmodule

`default_nettype wire

// ==== hdl/iccm_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_boot_params.svh"

// single port instruction RAM shared by the boot loader and the fetch port
module iccm_ram
  import soc_boot_pkg::*;
(
  input  logic                    clock,
  input  logic                    rst_ni,
  input  logic                    core_rst_ni,
  input  logic                    load_we_i,
  input  logic [`ICCM_ADDR_W-1:0] load_addr_i,
  input  logic [`WORD_W-1:0]      load_wdata_i,
  input  fetch_req_t              fetch_req_i,
  output fetch_rsp_t              fetch_rsp_o
);

  logic [`WORD_W-1:0]      mem_q [`ICCM_DEPTH];
  logic [`WORD_W-1:0]      rdata_q;
  logic                    rvalid_q;
  logic [`LOAD_BYTES-1:0]  fetch_be;
  logic [`LOAD_BYTES-1:0]  wr_be;
  logic [`ICCM_ADDR_W-1:0] wr_addr;
  logic [`WORD_W-1:0]      wr_data;
  logic                    fetch_en;
  logic                    fetch_wr;
  logic                    fetch_rd;
  logic                    load_wr;

  // a byte lane is written if any bit of its mask byte is set
  always_comb begin
    for (int i = 0; i < `LOAD_BYTES; i++) begin
      fetch_be[i] = |fetch_req_i.wmask[8*i +: 8];
    end
  end

  // fetch port is dead while the core is held in reset
  assign fetch_en = core_rst_ni & fetch_req_i.req;
  assign fetch_wr = fetch_en & fetch_req_i.we;
  assign fetch_rd = fetch_en & ~fetch_req_i.we;
  assign load_wr  = ~core_rst_ni & load_we_i;

  // port select, loader before boot and fetch after
  assign wr_addr = core_rst_ni ? fetch_req_i.addr  : load_addr_i;
  assign wr_data = core_rst_ni ? fetch_req_i.wdata : load_wdata_i;
  assign wr_be   = load_wr ? {`LOAD_BYTES{1'b1}} :
                   fetch_wr ? fetch_be : '0;

  always_ff @(posedge clock) begin
    for (int i = 0; i < `LOAD_BYTES; i++) begin
      if (wr_be[i]) begin
        mem_q[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_rd) begin
      rdata_q <= mem_q[fetch_req_i.addr];
    end
  end

  // read valid one cycle after the request, writes give none
  always_ff @(posedge clock) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= fetch_rd;
    end
  end

  assign fetch_rsp_o.rvalid = rvalid_q;
  assign fetch_rsp_o.rdata  = rdata_q;

  a_no_rvalid_after_write: assert property (@(posedge clock) disable iff (!rst_ni)
    (fetch_req_i.req && fetch_req_i.we) |=> !fetch_rsp_o.rvalid);

endmodule

`default_nettype wire

// ==== hdl/soc_boot_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_boot_params.svh"

// boot path: serial receiver, ICCM loader and the instruction RAM
module soc_boot_top
  import soc_boot_pkg::*;
(
  input  logic                   clock,
  input  logic                   rst_ni,
  input  logic                   uart_rx_i,
  input  logic [`BAUD_DIV_W-1:0] baud_div_i,
  input  fetch_req_t             fetch_req_i,
  output fetch_rsp_t             fetch_rsp_o,
  output logic                   core_rst_no
);

  // receiver to loader
  logic                    rx_dv;
  logic [7:0]              rx_byte;

  // loader to RAM
  logic                    load_we;
  logic [`ICCM_ADDR_W-1:0] load_addr;
  logic [`WORD_W-1:0]      load_wdata;

  uart_rx u_uart_rx (
    .clock      (clock),
    .rst_ni     (rst_ni),
    .rx_i       (uart_rx_i),
    .baud_div_i (baud_div_i),
    .rx_dv_o    (rx_dv),
    .rx_byte_o  (rx_byte)
  );

  // core reset also decides which port owns the RAM
  iccm_loader u_loader (
    .clock       (clock),
    .rst_ni      (rst_ni),
    .rx_dv_i     (rx_dv),
    .rx_byte_i   (rx_byte),
    .we_o        (load_we),
    .addr_o      (load_addr),
    .wdata_o     (load_wdata),
    .core_rst_no (core_rst_no)
  );

  iccm_ram u_iccm (
    .clock        (clock),
    .rst_ni       (rst_ni),
    .core_rst_ni  (core_rst_no),
    .load_we_i    (load_we),
    .load_addr_i  (load_addr),
    .load_wdata_i (load_wdata),
    .fetch_req_i  (fetch_req_i),
    .fetch_rsp_o  (fetch_rsp_o)
  );

endmodule

`default_nettype wire

// ==== sim/tb_soc_boot.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_boot_params.svh"

module tb_soc_boot
  import soc_boot_pkg::*;
();

  localparam int BAUD         = 8;
  localparam int N_WORDS      = 16;
  localparam int N_POST_BYTES = 4;
  localparam int N_FETCH_WR   = 8;
  localparam int N_BYTES      = (N_WORDS + 1) * `LOAD_BYTES + N_POST_BYTES;
  localparam int N_READS      = 1 + N_WORDS + N_WORDS + (N_WORDS + 1);
  localparam int N_WRITES     = N_FETCH_WR + 1;
  localparam int CYCLE_LIMIT  = 2 * (N_BYTES * 10 * BAUD + N_READS + N_WRITES + 100);

  logic                   clock;
  logic                   rst_ni;
  logic                   uart_rx_i;
  logic [`BAUD_DIV_W-1:0] baud_div_i;
  fetch_req_t             fetch_req_i;
  fetch_rsp_t             fetch_rsp_o;
  logic                   core_rst_no;

  // word-array model of the ICCM and the expected read responses in order
  logic [`WORD_W-1:0] model_mem [`ICCM_DEPTH];
  logic [`WORD_W-1:0] exp_q [$];
  logic [`WORD_W-1:0] exp_word;

  int         err_cnt;
  int         chk_cnt;
  int         test_cnt;
  int         test_fail;
  int         rvalid_cnt;
  int         cycle_cnt;
  int         errs;
  int         rv_before;
  int unsigned seed_val;
  load_word_u lw;
  logic [`ICCM_ADDR_W-1:0] wr_addr;
  logic [`WORD_W-1:0]      wr_data;
  logic [`WORD_W-1:0]      wr_mask;

  soc_boot_top i_dut (
    .clock       (clock),
    .rst_ni      (rst_ni),
    .uart_rx_i   (uart_rx_i),
    .baud_div_i  (baud_div_i),
    .fetch_req_i (fetch_req_i),
    .fetch_rsp_o (fetch_rsp_o),
    .core_rst_no (core_rst_no)
  );

  always #2 clock = ~clock;

  always @(posedge clock) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  // oldest outstanding read is matched against each response
  always @(negedge clock) begin
    if (rst_ni && fetch_rsp_o.rvalid === 1'b1) begin
      rvalid_cnt++;
      if (exp_q.size() == 0) begin
        $display("read response arrived with no read outstanding");
        err_cnt++;
      end else begin
        exp_word = exp_q.pop_front();
        check_rsp(fetch_rsp_o, exp_word);
      end
    end
  end

  // byte lane takes the new data if any bit of its mask byte is set
  function automatic logic [`WORD_W-1:0] merge_masked(input logic [`WORD_W-1:0] old_w,
                                                      input logic [`WORD_W-1:0] new_w,
                                                      input logic [`WORD_W-1:0] mask);
    logic [`WORD_W-1:0] res;
    res = old_w;
    for (int b = 0; b < `LOAD_BYTES; b++) begin
      if (mask[8*b +: 8] != 8'h00) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [`WORD_W-1:0] random_word();
    logic [`WORD_W-1:0] w;
    w = $urandom;
    while (w == `ICCM_END_WORD) begin
      w = $urandom;
    end
    return w;
  endfunction

  // some mask bytes cleared so that byte lanes stay untouched
  function automatic logic [`WORD_W-1:0] random_mask();
    logic [`WORD_W-1:0] m;
    m = $urandom;
    for (int b = 0; b < `LOAD_BYTES; b++) begin
      if ($urandom % 3 == 0) begin
        m[8*b +: 8] = 8'h00;
      end
    end
    return m;
  endfunction

  task automatic check_rsp(input fetch_rsp_t rsp, input logic [`WORD_W-1:0] exp_rdata);
    chk_cnt++;
    if (rsp.rdata !== exp_rdata) begin
      $display("CHECK FAILED fetch_rsp_o.rdata: got %h expected %h", rsp.rdata, exp_rdata);
      err_cnt++;
    end
  endtask

  task automatic check_rst(input logic exp_level);
    chk_cnt++;
    if (core_rst_no !== exp_level) begin
      $display("CHECK FAILED core_rst_no: got %h expected %h", core_rst_no, exp_level);
      err_cnt++;
    end
  endtask

  // 8N1 frame with start bit first and data lsb first
  task automatic uart_send_byte(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clock);
      uart_rx_i <= frame[i];
      repeat (BAUD - 1) @(posedge clock);
    end
  endtask

  task automatic fetch_read(input logic [`ICCM_ADDR_W-1:0] addr, input logic expect_rsp);
    fetch_req_t r;
    r       = '0;
    r.req   = 1'b1;
    r.addr  = addr;
    @(posedge clock);
    fetch_req_i <= r;
    if (expect_rsp) begin
      exp_q.push_back(model_mem[addr]);
    end
  endtask

  task automatic fetch_write(input logic [`ICCM_ADDR_W-1:0] addr,
                             input logic [`WORD_W-1:0] data,
                             input logic [`WORD_W-1:0] mask);
    fetch_req_t r;
    r       = '0;
    r.req   = 1'b1;
    r.we    = 1'b1;
    r.addr  = addr;
    r.wdata = data;
    r.wmask = mask;
    @(posedge clock);
    fetch_req_i <= r;
    model_mem[addr] = merge_masked(model_mem[addr], data, mask);
  endtask

  task automatic fetch_idle();
    @(posedge clock);
    fetch_req_i <= '0;
  endtask

  task automatic drain_reads();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 20) begin
      @(negedge clock);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d reads still without a response", exp_q.size());
      err_cnt++;
    end
  endtask

  task automatic wait_boot();
    int waited;
    waited = 0;
    while (core_rst_no !== 1'b1 && waited < 10 * BAUD) begin
      @(negedge clock);
      waited++;
    end
    if (core_rst_no !== 1'b1) begin
      $display("core reset was not released after the end marker");
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt != errs_before) begin
      test_fail++;
      $display("test %0d %s: FAIL", test_cnt, name);
    end else begin
      $display("test %0d %s: PASS", test_cnt, name);
    end
  endtask

  initial begin
    clock       = 1'b0;
    err_cnt     = 0;
    chk_cnt     = 0;
    test_cnt    = 0;
    test_fail   = 0;
    rvalid_cnt  = 0;
    cycle_cnt   = 0;
    rst_ni      <= 1'b0;
    uart_rx_i   <= 1'b1;
    baud_div_i  <= `BAUD_DIV_W'(BAUD);
    fetch_req_i <= '0;
    seed_val    = $urandom(36);
    repeat (16) @(posedge clock);
    rst_ni <= 1'b1;

    // fetch port is dead while loading
    errs = err_cnt;
    repeat (2) @(negedge clock);
    check_rst(1'b0);
    if (fetch_rsp_o.rvalid !== 1'b0) begin
      $display("CHECK FAILED fetch_rsp_o.rvalid: got %h expected %h", fetch_rsp_o.rvalid, 1'b0);
      err_cnt++;
    end
    rv_before = rvalid_cnt;
    fetch_read(`ICCM_ADDR_W'(5), 1'b0);
    fetch_idle();
    repeat (4) @(negedge clock);
    if (rvalid_cnt != rv_before) begin
      $display("a read issued during loading returned a response");
      err_cnt++;
    end
    end_test("reset state", errs);

    errs = err_cnt;
    for (int i = 0; i < N_WORDS; i++) begin
      lw.word = random_word();
      model_mem[i] = lw.word;
      for (int b = 0; b < `LOAD_BYTES; b++) begin
        uart_send_byte(lw.bytes[b]);
      end
    end
    lw.word = `ICCM_END_WORD;
    for (int b = 0; b < `LOAD_BYTES - 1; b++) begin
      uart_send_byte(lw.bytes[b]);
    end
    @(negedge clock);
    check_rst(1'b0);
    uart_send_byte(lw.bytes[`LOAD_BYTES-1]);
    wait_boot();
    check_rst(1'b1);
    end_test("serial load and boot", errs);

    errs = err_cnt;
    rv_before = rvalid_cnt;
    for (int i = 0; i < N_WORDS; i++) begin
      fetch_read(`ICCM_ADDR_W'(i), 1'b1);
    end
    fetch_idle();
    drain_reads();
    if (rvalid_cnt - rv_before != N_WORDS) begin
      $display("expected %0d read responses, saw %0d", N_WORDS, rvalid_cnt - rv_before);
      err_cnt++;
    end
    end_test("read back loaded words", errs);

    errs = err_cnt;
    for (int k = 0; k < N_FETCH_WR; k++) begin
      wr_addr = `ICCM_ADDR_W'($urandom % N_WORDS);
      wr_data = $urandom;
      wr_mask = random_mask();
      fetch_write(wr_addr, wr_data, wr_mask);
    end
    for (int i = 0; i < N_WORDS; i++) begin
      fetch_read(`ICCM_ADDR_W'(i), 1'b1);
    end
    fetch_idle();
    drain_reads();
    end_test("masked fetch writes", errs);

    // word 16 is where the loader would write next
    errs = err_cnt;
    fetch_write(`ICCM_ADDR_W'(N_WORDS), $urandom, '1);
    fetch_idle();
    for (int b = 0; b < N_POST_BYTES; b++) begin
      uart_send_byte(8'($urandom));
    end
    repeat (2 * BAUD) @(posedge clock);
    @(negedge clock);
    check_rst(1'b1);
    for (int i = 0; i <= N_WORDS; i++) begin
      fetch_read(`ICCM_ADDR_W'(i), 1'b1);
    end
    fetch_idle();
    drain_reads();
    end_test("bytes after boot ignored", errs);

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             test_cnt, test_fail, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
hdl/soc_boot_pkg.sv
hdl/uart_rx.sv
hdl/iccm_loader.sv
hdl/iccm_ram.sv
hdl/soc_boot_top.sv
sim/tb_soc_boot.sv

// ==== Bender.yml ====
package:
  name: soc_boot

sources:
  - include_dirs:
      - include
    files:
      - hdl/soc_boot_pkg.sv
      - hdl/uart_rx.sv
      - hdl/iccm_loader.sv
      - hdl/iccm_ram.sv
      - hdl/soc_boot_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_soc_boot.sv
